// File: common/tcb_cfg.svh
/* tcb bus configuration
   widths, response delay, slice lane granularity and sram depth */

`ifndef TCB_CFG_SVH
`define TCB_CFG_SVH

// address width in bits, word address
`define TCB_ABW 8
// data width in bits
`define TCB_DBW 32
// byte enables, one per data byte
`define TCB_BEW (`TCB_DBW/8)

// response delay after a downstream transfer
`define TCB_DLY 1

// slice lane granularity, bytes per enable lane
`define TCB_GRN 1

// sram word count, addresses at or above are errors
`define TCB_MEM_DEPTH 64

`endif

// File: common/tcb_pkg.sv
/* tcb bus types
   request and response packed structs shared by slice, sram and testbench */

`default_nettype none

`include "tcb_cfg.svh"

package tcb_pkg;

  //////////////////////////////
  // request
  //////////////////////////////

  typedef struct packed {
    logic                wen;  // write enable
    logic [`TCB_ABW-1:0] adr;  // word address
    logic [`TCB_BEW-1:0] ben;  // byte enables
    logic [`TCB_DBW-1:0] wdt;  // write data
  } tcb_req_t;

  //////////////////////////////
  // response
  //////////////////////////////

  // no ready on this channel, strobe only
  typedef struct packed {
    logic                vld;  // one cycle strobe
    logic [`TCB_DBW-1:0] rdt;  // read data
    logic                err;  // address out of range
  } tcb_rsp_t;

endpackage : tcb_pkg

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the tcb subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tcb_subsystem_tb \
  -o tcb_subsystem_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/tcb_subsystem_sim)"
printf '%s\n' "$out"
# status follows the pass line in the output
printf '%s\n' "$out" | grep -qx '>>> PASS' && exit 0 || exit 1

// File: source/tcb_sram.sv
/* tcb sram subordinate
   byte-enable writes, fixed-delay responses, write recovery stall, range error */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_cfg.svh"

module tcb_sram
  import tcb_pkg::*;
(
  input  logic     sub,
  input  logic     rst_n,
  input  logic     req_vld,
  output logic     req_rdy,
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  localparam int DEPTH = `TCB_MEM_DEPTH;
  localparam int DLY   = `TCB_DLY;
  localparam int BEW   = `TCB_BEW;
  // word index width
  localparam int IDW   = $clog2(DEPTH);
  // first illegal address, one bit wider than adr
  localparam logic [`TCB_ABW:0] LIM = (`TCB_ABW+1)'(DEPTH);

  logic [`TCB_DBW-1:0] mem [DEPTH];

  logic                trn;     // transfer this cycle
  logic                in_rng;  // address below depth
  logic [IDW-1:0]      idx;     // word index
  logic [`TCB_DBW-1:0] rd_dat;  // read data at transfer
  logic                rcv;     // write recovery

  // response delay line
  logic [DLY-1:0]      dly_vld;
  logic [`TCB_DBW-1:0] dly_rdt [DLY];
  logic [DLY-1:0]      dly_err;

  assign trn    = req_vld & req_rdy;
  assign in_rng = {1'b0, req.adr} < LIM;
  assign idx    = req.adr[IDW-1:0];

  //////////////////////////////
  // memory array
  //////////////////////////////

  // enabled bytes only, out of range writes dropped
  always_ff @(posedge sub) begin
    if (trn & req.wen & in_rng) begin
      for (int b = 0; b < BEW; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  // reads return the word, writes and errors return zero
  assign rd_dat = (in_rng & ~req.wen) ? mem[idx] : '0;

  //////////////////////////////
  // write recovery
  //////////////////////////////

  // one refused cycle after every accepted write
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rcv <= 1'b0;
    end else begin
      rcv <= trn & req.wen;
    end
  end

  assign req_rdy = ~rcv;

  //////////////////////////////
  // response delay line
  //////////////////////////////

  // strobe stages
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      dly_vld <= '0;
    end else begin
      dly_vld[0] <= trn;
      for (int i = 1; i < DLY; i++) begin
        dly_vld[i] <= dly_vld[i-1];
      end
    end
  end

  // payload stages, first one loads on transfer
  always_ff @(posedge sub) begin
    if (trn) begin
      dly_rdt[0] <= rd_dat;
      dly_err[0] <= ~in_rng;
    end
    for (int i = 1; i < DLY; i++) begin
      dly_rdt[i] <= dly_rdt[i-1];
      dly_err[i] <= dly_err[i-1];
    end
  end

  assign rsp.vld = dly_vld[DLY-1];
  assign rsp.rdt = dly_rdt[DLY-1];
  assign rsp.err = dly_err[DLY-1];

endmodule : tcb_sram

`default_nettype wire

// File: source/tcb_subsystem.sv
/* tcb subsystem top
   back-pressure register slice in front of the sram subordinate */

`timescale 1ns/1ps
`default_nettype none

module tcb_subsystem
  import tcb_pkg::*;
(
  input  logic     sub,
  input  logic     rst_n,
  input  logic     req_vld,
  output logic     req_rdy,
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  // slice to sram
  logic     man_vld;
  logic     man_rdy;
  tcb_req_t man_req;
  tcb_rsp_t man_rsp;

  tcb_register_backpressure i_tcb_register_backpressure (
    .sub     (sub),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .req     (req),
    .rsp     (rsp),
    .man_vld (man_vld),
    .man_rdy (man_rdy),
    .man_req (man_req),
    .man_rsp (man_rsp)
  );

  tcb_sram i_tcb_sram (
    .sub     (sub),
    .rst_n   (rst_n),
    .req_vld (man_vld),
    .req_rdy (man_rdy),
    .req     (man_req),
    .rsp     (man_rsp)
  );

endmodule : tcb_subsystem

`default_nettype wire

// File: tcb_register/tcb_register_backpressure.sv
/* tcb register slice on the back-pressure path
   upstream ready is a register, one request skids while downstream stalls */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_cfg.svh"

module tcb_register_backpressure
  import tcb_pkg::*;
#(
  // bytes per captured write data lane, 1, 2 or 4
  parameter int GRN = `TCB_GRN
)(
  input  logic     sub,
  input  logic     rst_n,
  // upstream side, manager connects here
  input  logic     req_vld,
  output logic     req_rdy,
  input  tcb_req_t req,
  output tcb_rsp_t rsp,
  // downstream side, subordinate connects here
  output logic     man_vld,
  input  logic     man_rdy,
  output tcb_req_t man_req,
  input  tcb_rsp_t man_rsp
);

  localparam int BEW = `TCB_BEW;
  // lane width in bits
  localparam int LNW = 8 * GRN;

  //////////////////////////////
  // skid register
  //////////////////////////////

  // copy of the request accepted during a stall
  tcb_req_t skd;
  // upstream transfer meets stalled downstream
  logic     skd_ld;

  assign skd_ld = req_vld & req_rdy & ~man_rdy;

  always_ff @(posedge sub) begin
    if (skd_ld) begin
      skd.wen <= req.wen;
      skd.adr <= req.adr;
      skd.ben <= req.ben;
      // write data in lane steps
      // lane enable is the first byte enable of the lane
      for (int i = 0; i < BEW; i += GRN) begin
        if (req.wen & req.ben[i]) begin
          skd.wdt[8*i +: LNW] <= req.wdt[8*i +: LNW];
        end
      end
    end
  end

  //////////////////////////////
  // upstream ready
  //////////////////////////////

  // falls after a transfer into a stall
  // rises one cycle after downstream ready is seen
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      req_rdy <= 1'b1;
    end else if (req_rdy) begin
      req_rdy <= ~(req_vld & ~man_rdy);
    end else begin
      req_rdy <= man_rdy;
    end
  end

  //////////////////////////////
  // downstream mux
  //////////////////////////////

  // live request while ready is high, zero latency
  // skid copy otherwise, always valid then
  assign man_vld = req_rdy ? req_vld : 1'b1;
  assign man_req = req_rdy ? req : skd;

  //////////////////////////////
  // response
  //////////////////////////////

  // plain pass-through, no back-pressure on responses
  assign rsp = man_rsp;

endmodule : tcb_register_backpressure

`default_nettype wire

// File: verif/tcb_subsystem_assert.sv
/* tcb register slice protocol checks
   bound into every back-pressure slice instance */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_cfg.svh"

module tcb_register_backpressure_assert
  import tcb_pkg::*;
(
  input logic     sub,
  input logic     rst_n,
  input logic     req_vld,
  input logic     req_rdy,
  input logic     man_vld,
  input logic     man_rdy,
  input tcb_req_t man_req
);

  localparam int BEW = `TCB_BEW;
  localparam int GRN = `TCB_GRN;

  // write data lanes that carry meaning
  logic [`TCB_DBW-1:0]         msk;
  // payload as the subordinate sees it
  logic [$bits(tcb_req_t)-1:0] pld;

  // lane enable is the first byte enable of the lane
  always_comb begin
    for (int b = 0; b < BEW; b++) begin
      msk[8*b +: 8] = {8{man_req.wen & man_req.ben[b - (b % GRN)]}};
    end
  end

  assign pld = {man_req.wen, man_req.adr, man_req.ben, man_req.wdt & msk};

  //////////////////////////////
  // slice protocol
  //////////////////////////////

  a_rdy_after_rst : assert property (@(posedge sub) $rose(rst_n) |-> req_rdy)
    else $error("slice upstream ready low in first cycle after reset");

  // skid copy is always offered downstream
  a_vld_while_held : assert property (@(posedge sub) disable iff (!rst_n)
    !req_rdy |-> man_vld)
    else $error("slice downstream valid low while upstream ready low");

  a_hold_on_stall : assert property (@(posedge sub) disable iff (!rst_n)
    man_vld && !man_rdy |=> man_vld && $stable(pld))
    else $error("slice downstream request changed under stall");

  a_rdy_fall : assert property (@(posedge sub) disable iff (!rst_n)
    $fell(req_rdy) |-> $past(req_vld && req_rdy && !man_rdy))
    else $error("slice upstream ready fell without a stalled transfer");

endmodule : tcb_register_backpressure_assert

bind tcb_register_backpressure tcb_register_backpressure_assert
  i_tcb_register_backpressure_assert (
  .sub     (sub),
  .rst_n   (rst_n),
  .req_vld (req_vld),
  .req_rdy (req_rdy),
  .man_vld (man_vld),
  .man_rdy (man_rdy),
  .man_req (man_req)
);

`default_nettype wire

// File: verif/tcb_subsystem_tb.sv
/* tcb subsystem testbench
   directed and random traffic against a reference memory model */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_cfg.svh"

module tcb_subsystem_tb
  import tcb_pkg::*;
();

  localparam int DEPTH = `TCB_MEM_DEPTH;
  localparam int BEW   = `TCB_BEW;
  localparam int IDW   = $clog2(DEPTH);
  localparam int TMO   = 64;

  // expected response
  typedef struct packed {
    logic                chk;  // rdt is compared
    logic [`TCB_DBW-1:0] rdt;
    logic                err;
  } exp_rsp_t;

  logic     sub;
  logic     rst_n;
  logic     req_vld;
  logic     req_rdy;
  tcb_req_t req;
  tcb_rsp_t rsp;

  logic [`TCB_DBW-1:0] ref_mem [DEPTH];
  exp_rsp_t            exp_q [$];
  exp_rsp_t            exp_hd;
  int                  errors;
  int                  passed;
  int                  failed;
  int                  seed;

  tcb_subsystem i_tcb_subsystem (
    .sub     (sub),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .req     (req),
    .rsp     (rsp)
  );

  always #2 sub = ~sub;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // applied in upstream order which is also downstream order
  task automatic record_transfer(input tcb_req_t r);
    exp_rsp_t e;
    e = '0;
    e.chk = ~r.wen;
    if (int'(r.adr) >= DEPTH) begin
      // zero read data on any range error
      e.chk = 1'b1;
      e.err = 1'b1;
    end else if (r.wen) begin
      for (int b = 0; b < BEW; b++) begin
        if (r.ben[b]) begin
          ref_mem[r.adr[IDW-1:0]][8*b +: 8] = r.wdt[8*b +: 8];
        end
      end
    end else begin
      e.rdt = ref_mem[r.adr[IDW-1:0]];
    end
    exp_q.push_back(e);
  endtask

  // registered outputs read before the edge updates them
  always @(posedge sub) begin
    if (rst_n) begin
      if (rsp.vld) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response at %0t with no request outstanding", $time);
          errors++;
        end else begin
          exp_hd = exp_q.pop_front();
          assert (rsp.err == exp_hd.err) else begin
            $display("FAILED %0t err %0b expected %0b", $time, rsp.err, exp_hd.err);
            errors++;
          end
          assert (!exp_hd.chk || rsp.rdt == exp_hd.rdt) else begin
            $display("FAILED %0t rdt %h expected %h", $time, rsp.rdt, exp_hd.rdt);
            errors++;
          end
        end
      end
      if (req_vld && req_rdy) begin
        record_transfer(req);
      end
    end
  end

  //////////////////////////////
  // drivers
  //////////////////////////////

  // returns on the falling edge after the transfer with valid still high
  task automatic issue(input logic wen, input int adr, input logic [`TCB_BEW-1:0] ben,
                       input logic [`TCB_DBW-1:0] wdt);
    int cnt;
    cnt = 0;
    req_vld = 1'b1;
    req.wen = wen;
    req.adr = `TCB_ABW'(adr);
    req.ben = ben;
    req.wdt = wdt;
    while (!req_rdy && cnt < TMO) begin
      @(negedge sub);
      cnt++;
    end
    if (!req_rdy) begin
      $display("request to address %0d was never accepted", adr);
      errors++;
      req_vld = 1'b0;
    end else begin
      @(posedge sub);
      @(negedge sub);
    end
  endtask

  task automatic idle(input int n);
    req_vld = 1'b0;
    repeat (n) @(negedge sub);
  endtask

  task automatic drain();
    int cnt;
    cnt = 0;
    idle(1);
    while (exp_q.size() != 0 && cnt < TMO) begin
      @(negedge sub);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("lost response, %0d expected responses never arrived", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic report(input string name, input int err0);
    if (errors == err0) begin
      passed++;
      $display("test %s ok", name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", name, errors - err0);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic check_reset();
    assert (req_rdy) else begin
      $display("FAILED %0t req_rdy low after reset", $time);
      errors++;
    end
    // any response here is unexpected
    idle(10);
  endtask

  task automatic read_after_write();
    for (int a = 0; a < 4; a++) begin
      issue(1'b1, a * 5, 4'hf, 32'hc0de_0000 + 32'(a));
      idle(2);
    end
    for (int a = 0; a < 4; a++) begin
      issue(1'b0, a * 5, 4'hf, '0);
      idle(1);
    end
  endtask

  // back-to-back writes stall the sram after each one
  task automatic burst_backpressure();
    for (int a = 0; a < DEPTH; a++) begin
      issue(1'b1, a, 4'hf, (32'(a) * 32'h0101_0101) ^ 32'h5a5a_0000);
    end
    for (int a = 0; a < DEPTH; a++) begin
      issue(1'b0, a, 4'hf, '0);
    end
  endtask

  task automatic byte_enables();
    for (int a = 0; a < 16; a++) begin
      issue(1'b1, a, 4'(a), $random(seed));
    end
    for (int a = 0; a < 16; a++) begin
      issue(1'b0, a, 4'hf, '0);
    end
  endtask

  task automatic range_error();
    for (int a = DEPTH; a < DEPTH + 4; a++) begin
      issue(1'b1, a, 4'hf, 32'hdead_beef);
    end
    for (int a = DEPTH; a < DEPTH + 8; a++) begin
      issue(1'b0, a, 4'hf, '0);
    end
    // aliased low words untouched
    for (int a = 0; a < 4; a++) begin
      issue(1'b0, a, 4'hf, '0);
    end
  endtask

  task automatic random_mix();
    int adr;
    int gap;
    for (int n = 0; n < 200; n++) begin
      adr = int'({$random(seed)} % (DEPTH + 8));
      gap = int'({$random(seed)} % 3);
      issue(1'($random(seed)), adr, 4'($random(seed)), $random(seed));
      if (gap != 0) begin
        idle(gap);
      end
    end
  endtask

  task automatic run(input int id);
    case (id)
      0: check_reset();
      1: read_after_write();
      2: burst_backpressure();
      3: byte_enables();
      4: range_error();
      default: random_mix();
    endcase
    drain();
  endtask

  initial begin
    string names [6];
    int    err0;
    names = '{"reset", "read_after_write", "backpressure", "byte_enables",
              "range_error", "random_mix"};
    sub     = 1'b0;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req     = '0;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    seed    = 70;
    for (int i = 0; i < DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    repeat (3) @(posedge sub);
    @(negedge sub);
    rst_n = 1'b1;
    @(negedge sub);
    for (int t = 0; t < 6; t++) begin
      err0 = errors;
      run(t);
      report(names[t], err0);
    end
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tcb_subsystem_tb

`default_nettype wire

// File: vlog.f
+incdir+common
common/tcb_pkg.sv
tcb_register/tcb_register_backpressure.sv
source/tcb_sram.sv
source/tcb_subsystem.sv
verif/tcb_subsystem_assert.sv
verif/tcb_subsystem_tb.sv
